// File: compile.f
+incdir+verification
hdl/wb_slave_pkg.sv
hdl/wb_access_ctrl.sv
hdl/wb_policy_regs.sv
hdl/wb_byte_mem.sv
hdl/wb_slave_top.sv
verification/wb_slave_tb.sv

// File: hdl/wb_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wb_access_ctrl
  import wb_slave_pkg::*;
#(
  parameter int WAIT_CYCLES = 2  // Wait states before ACK or ERR
) (
  input  logic RST_I,      // Clock
  input  logic CLK_I,      // Async reset, active high
  input  logic cyc_i,
  input  logic stb_i,
  input  logic we_i,
  input  adr_t adr_i,
  output logic ack_o,
  output logic err_o,
  output logic commit_o,   // Strobe into RESP on a mapped address
  output logic reg_sel_o,  // Register space hit
  output logic mem_sel_o   // Memory region hit
);

  localparam logic [3:0] WAIT_LAST = 4'(WAIT_CYCLES);  // Last count before RESP

  ctrl_state_t state_q;
  logic [3:0]  wait_cnt_q;  // Wait states seen so far
  logic        req;         // Live request
  logic        hit;         // Address is mapped
  logic        resp_fire;   // Response due at next edge

  assign req       = cyc_i & stb_i;
  assign reg_sel_o = (adr_i < REG_LIMIT);
  assign mem_sel_o = (adr_i > REG_LIMIT) && (adr_i < MEM_LIMIT);  // 0x400 itself is unmapped
  assign hit       = reg_sel_o | mem_sel_o;
  assign resp_fire = (state_q == WAIT) && req && (wait_cnt_q == WAIT_LAST);
  assign commit_o  = resp_fire & hit;  // No commit on ERR

  always_ff @(posedge RST_I or posedge CLK_I) begin
    if (CLK_I) begin
      state_q    <= IDLE;
      wait_cnt_q <= '0;
      ack_o      <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      ack_o <= resp_fire & hit;   // One cycle pulse
      err_o <= resp_fire & ~hit;
      case (state_q)
        IDLE: begin
          if (req) begin
            state_q    <= WAIT;  // Sampling edge
            wait_cnt_q <= '0;
          end
        end
        WAIT: begin
          if (!req) begin
            state_q <= IDLE;  // Abandoned without a response
          end else if (resp_fire) begin
            state_q <= RESP;
          end else begin
            wait_cnt_q <= wait_cnt_q + 4'd1;
          end
        end
        RESP:    state_q <= IDLE;  // Forced idle cycle between requests
        default: state_q <= IDLE;
      endcase
    end
  end

  a_resp_excl : assert property (@(posedge RST_I) disable iff (CLK_I)
    !(ack_o && err_o));

  // Commit lands exactly on the edge into RESP with ACK raised
  a_commit_resp : assert property (@(posedge RST_I) disable iff (CLK_I)
    commit_o |=> (state_q == RESP) && ack_o);

  // Master keeps the request stable while it is pending
  a_req_stable : assert property (@(posedge RST_I) disable iff (CLK_I)
    (state_q == WAIT) && req |=> !req || ($stable(adr_i) && $stable(we_i)));

endmodule

`default_nettype wire

// File: hdl/wb_byte_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_byte_mem
  import wb_slave_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 13  // Word index width
) (
  input  logic                     RST_I,       // Clock
  input  logic                     commit_i,    // Memory region commit only
  input  logic                     we_i,
  input  logic [MEM_ADDR_BITS-1:0] word_adr_i,
  input  sel_t                     sel_i,
  input  dat_t                     dat_i,
  output dat_t                     rd_data_o
);

  localparam int DEPTH = 1 << MEM_ADDR_BITS;  // Words in the array

  dat_t mem_q [DEPTH];

  // Each word starts as its own byte address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem_q[i] = dat_t'(i * 4);
    end
  end

  always @(posedge RST_I) begin
    if (commit_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          mem_q[word_adr_i][8*b +: 8] <= dat_i[8*b +: 8];  // Enabled lanes only
        end
      end
    end
  end

  assign rd_data_o = mem_q[word_adr_i];  // Async read

endmodule

`default_nettype wire

// File: hdl/wb_policy_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_policy_regs
  import wb_slave_pkg::*;
(
  input  logic       RST_I,      // Clock
  input  logic       CLK_I,      // Async reset, active high
  input  logic       commit_i,   // Register space commit only
  input  logic       we_i,
  input  logic [7:0] offset_i,   // Low address byte
  input  dat_t       dat_i,
  output dat_t       rd_data_o   // Value before any side effect
);

  localparam reg_t RO_VAL = reg_t'(OFS_RO);  // Hardwired read only value

  reg_t rw_q;
  reg_t rc_q;
  reg_t rs_q;
  reg_t w1c_q;
  reg_t w1s_q;
  reg_t w1t_q;
  reg_t w0c_q;
  reg_t w1_q;
  logic w1_done_q;  // W1 already written since reset
  reg_t alias_q;    // Alias source storage
  reg_t index_q;
  reg_t wr_field;   // Write data field

  assign wr_field = dat_i[15:0];

  always_ff @(posedge RST_I or posedge CLK_I) begin
    if (CLK_I) begin
      rw_q      <= reg_t'(OFS_RW);
      rc_q      <= reg_t'(OFS_RC);
      rs_q      <= reg_t'(OFS_RS);
      w1c_q     <= reg_t'(OFS_W1C);
      w1s_q     <= reg_t'(OFS_W1S);
      w1t_q     <= reg_t'(OFS_W1T);
      w0c_q     <= reg_t'(OFS_W0C);
      w1_q      <= reg_t'(OFS_W1);
      w1_done_q <= 1'b0;
      alias_q   <= reg_t'(OFS_ALIAS_SRC);
      index_q   <= reg_t'(OFS_INDEX);
    end else if (commit_i) begin
      if (we_i) begin
        case (offset_i)
          OFS_RW:  rw_q  <= wr_field;
          OFS_W1C: w1c_q <= w1c_q & ~wr_field;  // Ones clear
          OFS_W1S: w1s_q <= w1s_q | wr_field;   // Ones set
          OFS_W1T: w1t_q <= w1t_q ^ wr_field;   // Ones flip
          OFS_W0C: w0c_q <= w0c_q & wr_field;   // Zeros clear
          OFS_W1: begin
            if (!w1_done_q) begin
              w1_q      <= wr_field;  // First write only
              w1_done_q <= 1'b1;
            end
          end
          OFS_ALIAS_SRC: alias_q <= wr_field;
          OFS_INDEX:     index_q <= wr_field;
          default: ;  // Read only or unlisted
        endcase
      end else begin
        case (offset_i)
          OFS_RC:  rc_q <= '0;  // Cleared by the read
          OFS_RS:  rs_q <= '1;  // Set by the read
          default: ;
        endcase
      end
    end
  end

  // Read path from current state
  always_comb begin
    rd_data_o = '0;  // Unlisted and write only offsets
    case (offset_i)
      OFS_CHIP_ID:  rd_data_o = CHIP_ID_VAL;
      OFS_RO:       rd_data_o = {16'h0, RO_VAL};
      OFS_RW:       rd_data_o = {16'h0, rw_q};
      OFS_RC:       rd_data_o = {16'h0, rc_q};
      OFS_RS:       rd_data_o = {16'h0, rs_q};
      OFS_W1C:      rd_data_o = {16'h0, w1c_q};
      OFS_W1S:      rd_data_o = {16'h0, w1s_q};
      OFS_W1T:      rd_data_o = {16'h0, w1t_q};
      OFS_W0C:      rd_data_o = {16'h0, w0c_q};
      OFS_W1:       rd_data_o = {16'h0, w1_q};
      OFS_ALIAS_VW: rd_data_o = {16'h0, alias_q};  // View of the source
      OFS_INDEX:    rd_data_o = {16'h0, index_q};
      default:      rd_data_o = '0;
    endcase
  end

  // Once written, W1 stays locked with its value frozen
  a_w1_once : assert property (@(posedge RST_I) disable iff (CLK_I)
    w1_done_q |=> w1_done_q && $stable(w1_q));

endmodule

`default_nettype wire

// File: hdl/wb_slave_pkg.sv
`default_nettype none

package wb_slave_pkg;

  typedef logic [31:0] adr_t;  // Wishbone byte address
  typedef logic [31:0] dat_t;  // Wishbone data word
  typedef logic [3:0]  sel_t;  // One select bit per data byte
  typedef logic [15:0] reg_t;  // Policy register field width

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Waiting for cyc and stb
    WAIT = 2'd1,  // Counting wait states
    RESP = 2'd2   // ACK or ERR cycle
  } ctrl_state_t;

  localparam adr_t REG_LIMIT = 32'h0000_0400;  // First address past register space
  localparam adr_t MEM_LIMIT = 32'h0000_8000;  // First address past memory

  localparam dat_t CHIP_ID_VAL = 32'h0176_5a03;  // Fixed device ID

  // Register byte offsets that double as reset values
  localparam logic [7:0] OFS_CHIP_ID   = 8'h00;
  localparam logic [7:0] OFS_RO        = 8'h0c;  // Read only
  localparam logic [7:0] OFS_RW        = 8'h10;  // Read and write
  localparam logic [7:0] OFS_RC        = 8'h14;  // Read clears
  localparam logic [7:0] OFS_RS        = 8'h18;  // Read sets all
  localparam logic [7:0] OFS_W1C       = 8'h34;  // Write 1 to clear
  localparam logic [7:0] OFS_W1S       = 8'h38;  // Write 1 to set
  localparam logic [7:0] OFS_W1T       = 8'h3c;  // Write 1 to toggle
  localparam logic [7:0] OFS_W0C       = 8'h40;  // Write 0 to clear
  localparam logic [7:0] OFS_W1        = 8'h68;  // Write once
  localparam logic [7:0] OFS_ALIAS_SRC = 8'h70;  // Write only source
  localparam logic [7:0] OFS_ALIAS_VW  = 8'h74;  // Read only view of source
  localparam logic [7:0] OFS_INDEX     = 8'h78;  // Index register

endpackage

`default_nettype wire

// File: hdl/wb_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_slave_top
  import wb_slave_pkg::*;
#(
  parameter int WAIT_CYCLES   = 2,   // Wait states per transfer
  parameter int MEM_ADDR_BITS = 13   // Memory word index width
) (
  input  logic RST_I,   // Clock
  input  logic CLK_I,   // Async reset, active high
  input  logic cyc_i,
  input  logic stb_i,
  input  logic we_i,
  input  adr_t adr_i,
  input  sel_t sel_i,
  input  dat_t dat_i,
  output logic ack_o,
  output logic err_o,
  output dat_t dat_o
);

  logic commit;       // Commit strobe from controller
  logic reg_sel;
  logic mem_sel;
  dat_t reg_rd_data;
  dat_t mem_rd_data;

  wb_access_ctrl #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_ctrl (
    .RST_I     (RST_I),
    .CLK_I     (CLK_I),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .adr_i     (adr_i),
    .ack_o     (ack_o),
    .err_o     (err_o),
    .commit_o  (commit),
    .reg_sel_o (reg_sel),
    .mem_sel_o (mem_sel)
  );

  wb_policy_regs u_regs (
    .RST_I     (RST_I),
    .CLK_I     (CLK_I),
    .commit_i  (commit & reg_sel),  // Register space only
    .we_i      (we_i),
    .offset_i  (adr_i[7:0]),
    .dat_i     (dat_i),
    .rd_data_o (reg_rd_data)
  );

  wb_byte_mem #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) u_mem (
    .RST_I      (RST_I),
    .commit_i   (commit & mem_sel),  // Memory region only
    .we_i       (we_i),
    .word_adr_i (adr_i[MEM_ADDR_BITS+1:2]),  // Word index from byte address
    .sel_i      (sel_i),
    .dat_i      (dat_i),
    .rd_data_o  (mem_rd_data)
  );

  // Read data captured before the side effect lands
  always_ff @(posedge RST_I or posedge CLK_I) begin
    if (CLK_I) begin
      dat_o <= '0;
    end else if (commit) begin
      dat_o <= we_i ? '0 : (reg_sel ? reg_rd_data : mem_rd_data);  // Zero on writes
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module wb_slave_tb -o wb_slave_sim \
  && ./obj_dir/wb_slave_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"
exit 0

// File: verification/wb_slave_model.svh
`ifndef WB_SLAVE_MODEL_SVH
`define WB_SLAVE_MODEL_SVH

reg_t m_reg [256];  // Shadow fields indexed by offset
logic m_w1_done;    // W1 already written
dat_t m_mem [int];  // Written memory words only

function automatic void model_reset();
  for (int i = 0; i < 256; i++) begin
    m_reg[i] = reg_t'(i);  // Each register resets to its offset
  end
  m_w1_done = 1'b0;
endfunction

function automatic dat_t model_reg_read(logic [7:0] ofs);
  case (ofs)
    OFS_CHIP_ID:  return CHIP_ID_VAL;
    OFS_RO:       return {16'h0, reg_t'(OFS_RO)};
    OFS_RW, OFS_RC, OFS_RS, OFS_W1C, OFS_W1S, OFS_W1T, OFS_W0C, OFS_W1, OFS_INDEX:
      return {16'h0, m_reg[ofs]};
    OFS_ALIAS_VW: return {16'h0, m_reg[OFS_ALIAS_SRC]};  // View of the source
    default:      return 32'h0;  // Alias source and unlisted
  endcase
endfunction

function automatic void model_reg_write(logic [7:0] ofs, reg_t d);
  case (ofs)
    OFS_RW, OFS_ALIAS_SRC, OFS_INDEX: m_reg[ofs] = d;
    OFS_W1C: m_reg[ofs] = m_reg[ofs] & ~d;
    OFS_W1S: m_reg[ofs] = m_reg[ofs] | d;
    OFS_W1T: m_reg[ofs] = m_reg[ofs] ^ d;
    OFS_W0C: m_reg[ofs] = m_reg[ofs] & d;
    OFS_W1: begin
      if (!m_w1_done) begin
        m_reg[ofs] = d;  // Only the first write lands
        m_w1_done  = 1'b1;
      end
    end
    default: ;
  endcase
endfunction

// Applies one transfer and returns the expected response
function automatic void model_access(input logic w, input adr_t a, input sel_t s,
                                     input dat_t d, output logic exp_err,
                                     output dat_t exp_data);
  int   idx;
  dat_t word;
  exp_err  = 1'b0;
  exp_data = 32'h0;  // Writes return zero
  if (a < REG_LIMIT) begin
    if (w) begin
      model_reg_write(a[7:0], d[15:0]);
    end else begin
      exp_data = model_reg_read(a[7:0]);  // Value before the side effect
      if (a[7:0] == OFS_RC) m_reg[OFS_RC] = 16'h0;
      if (a[7:0] == OFS_RS) m_reg[OFS_RS] = 16'hffff;
    end
  end else if (a > REG_LIMIT && a < MEM_LIMIT) begin
    idx  = int'(a[14:2]);
    word = m_mem.exists(idx) ? m_mem[idx] : dat_t'(idx * 4);  // Fresh word is index times 4
    if (w) begin
      for (int b = 0; b < 4; b++) begin
        if (s[b]) word[8*b +: 8] = d[8*b +: 8];
      end
      m_mem[idx] = word;
    end else begin
      exp_data = word;
    end
  end else begin
    exp_err = 1'b1;  // Unmapped so nothing changes
  end
endfunction

`endif

// File: verification/wb_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_slave_tb
  import wb_slave_pkg::*;
();

  localparam int WAIT_CYCLES    = 2;
  localparam int NUM_TXN        = 600;                            // Upper bound on transfers
  localparam int TIMEOUT_CYCLES = NUM_TXN * (WAIT_CYCLES + 3) * 7;  // About 20000
  localparam int RESP_LIMIT     = WAIT_CYCLES + 20;               // Edges per response
  localparam logic [7:0] REG_OFS [13] = '{OFS_CHIP_ID, OFS_RO, OFS_RW, OFS_RC, OFS_RS,
    OFS_W1C, OFS_W1S, OFS_W1T, OFS_W0C, OFS_W1, OFS_ALIAS_SRC, OFS_ALIAS_VW, OFS_INDEX};

  logic        clk;   // Drives RST_I
  logic        rst;   // Drives CLK_I
  logic        cyc;
  logic        stb;
  logic        we;
  adr_t        adr;
  sel_t        sel;
  dat_t        wdat;
  logic        ack;
  logic        err;
  dat_t        rdat;
  logic [31:0] seed;
  int          cycles;
  int          checks;
  int          errors;

  `include "wb_slave_model.svh"

  wb_slave_top #(
    .WAIT_CYCLES   (WAIT_CYCLES),
    .MEM_ADDR_BITS (13)
  ) dut_i (
    .RST_I (clk),
    .CLK_I (rst),
    .cyc_i (cyc),
    .stb_i (stb),
    .we_i  (we),
    .adr_i (adr),
    .sel_i (sel),
    .dat_i (wdat),
    .ack_o (ack),
    .err_o (err),
    .dat_o (rdat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("%s", msg);
  endtask

  // One full transfer started 1 ns after an edge with the bus idle
  task automatic bus_transfer(input logic w, input adr_t a, input sel_t s, input dat_t d);
    logic exp_err;
    dat_t exp_data;
    int   edges;
    logic got_ack;
    logic got_err;
    model_access(w, a, s, d, exp_err, exp_data);
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = w;
    adr     = a;
    sel     = s;
    wdat    = d;
    edges   = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    while (!got_ack && !got_err && edges < RESP_LIMIT) begin
      @(posedge clk);
      #1;
      edges++;  // First edge samples the request
      got_ack = ack;
      got_err = err;
    end
    cyc = 1'b0;
    stb = 1'b0;
    checks++;
    if (!got_ack && !got_err) begin
      report_error($sformatf("no response for adr %h", a));
    end else if (got_ack && got_err) begin
      report_error($sformatf("ack_o and err_o raised together for adr %h", a));
    end else if (got_err != exp_err) begin
      report_error($sformatf("mismatch err_o adr=%h got=%h exp=%h", a, got_err, exp_err));
    end else if (edges != WAIT_CYCLES + 2) begin
      report_error($sformatf("response for adr %h came %0d edges after the request", a,
                             edges - 1));
    end else if (got_ack && rdat !== exp_data) begin
      report_error($sformatf("mismatch dat_o adr=%h got=%h exp=%h", a, rdat, exp_data));
    end
    @(posedge clk);
    #1;
    if (ack || err) report_error($sformatf("response for adr %h held past one cycle", a));
  endtask

  // Request dropped right after its sampling edge
  task automatic abandoned_transfer(input logic w, input adr_t a, input dat_t d);
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = w;
    adr  = a;
    sel  = 4'hf;
    wdat = d;
    @(posedge clk);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    for (int i = 0; i < WAIT_CYCLES + 3; i++) begin
      checks++;
      if (ack || err) report_error($sformatf("abandoned request at adr %h got a response", a));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(string name, int start_errors);
    $display("test %-14s done, %0d errors", name, errors - start_errors);
  endtask

  initial begin
    int          start;
    logic [31:0] r;
    int          idx;
    seed   = 32'hb8da;
    cycles = 0;
    checks = 0;
    errors = 0;
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = 32'h0;
    sel    = 4'h0;
    wdat   = 32'h0;
    model_reset();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    #1;

    start = errors;
    for (int i = 0; i < 13; i++) bus_transfer(1'b0, adr_t'(REG_OFS[i]), 4'hf, 32'h0);
    end_test("reset_values", start);

    start = errors;  // Edge count is checked in every transfer
    for (int i = 0; i < 10; i++) begin
      bus_transfer(1'b0, 32'h0000_0010, 4'hf, 32'h0);
      bus_transfer(1'b0, adr_t'(32'h0000_0404 + 4 * i), 4'hf, 32'h0);
    end
    end_test("timing", start);

    start = errors;
    bus_transfer(1'b1, adr_t'(OFS_W1), 4'hf, 32'h0000_1234);
    bus_transfer(1'b1, adr_t'(OFS_W1), 4'hf, 32'h0000_beef);  // Must be ignored
    bus_transfer(1'b0, adr_t'(OFS_W1), 4'hf, 32'h0);
    repeat (250) begin
      r = next_rand();
      bus_transfer(r[31], adr_t'(REG_OFS[int'(r[23:16] % 8'd13)]), 4'hf, next_rand());
    end
    end_test("reg_policies", start);

    start = errors;
    bus_transfer(1'b0, 32'h0000_0404, 4'hf, 32'h0);  // First mapped word
    bus_transfer(1'b0, 32'h0000_7ffc, 4'hf, 32'h0);  // Last mapped word
    repeat (16) begin
      r   = next_rand();
      idx = 257 + int'(r[23:8] % 16'd7935);
      bus_transfer(1'b0, adr_t'(idx * 4), 4'hf, 32'h0);
    end
    repeat (200) begin
      r   = next_rand();
      idx = 257 + int'(r[13:8]);  // Small window so reads hit writes
      bus_transfer(r[31], adr_t'(idx * 4), r[19:16], next_rand());
    end
    end_test("memory", start);

    start = errors;
    bus_transfer(1'b1, 32'h0000_0400, 4'hf, 32'hffff_ffff);
    bus_transfer(1'b1, 32'h0000_8010, 4'hf, 32'h0000_5555);  // Low byte aliases RW
    bus_transfer(1'b1, 32'h0000_803c, 4'hf, 32'h0000_ffff);  // Low byte aliases W1T
    bus_transfer(1'b1, 32'h0000_8404, 4'hf, 32'h5a5a_5a5a);  // Word bits alias 0x404
    bus_transfer(1'b0, 32'hffff_fffc, 4'hf, 32'h0);
    repeat (4) begin
      r = next_rand();
      bus_transfer(r[0], {1'b1, r[31:3], 2'b00}, 4'hf, next_rand());
    end
    bus_transfer(1'b0, 32'h0000_0010, 4'hf, 32'h0);
    bus_transfer(1'b0, 32'h0000_003c, 4'hf, 32'h0);
    bus_transfer(1'b0, 32'h0000_0404, 4'hf, 32'h0);
    end_test("error_resp", start);

    start = errors;
    abandoned_transfer(1'b1, 32'h0000_0010, 32'h0000_c3c3);
    abandoned_transfer(1'b1, 32'h0000_003c, 32'h0000_ffff);
    abandoned_transfer(1'b1, 32'h0000_0404, 32'hdead_beef);
    bus_transfer(1'b0, 32'h0000_0010, 4'hf, 32'h0);
    bus_transfer(1'b0, 32'h0000_003c, 4'hf, 32'h0);
    bus_transfer(1'b0, 32'h0000_0404, 4'hf, 32'h0);
    end_test("abandoned", start);

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
